// ==== rv_isa_pkg.sv ====
// RV32I base encodings only; no compressed, CSR or fence opcodes are defined
package rv_isa_pkg;

    typedef logic [31:0] word_t;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // encoded as {instr[30], funct3} so the decoder can pass the fields through
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_t;

    // same as funct3 of loads and stores
    typedef enum logic [2:0] {
        MB  = 3'b000,
        MH  = 3'b001,
        MW  = 3'b010,
        MBU = 3'b100,
        MHU = 3'b101
    } mem_width_t;

    // same as funct3 of conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

endpackage

// ==== rv_pipe_pkg.sv ====
// single core configuration; reset vector and register count are fixed here
package rv_pipe_pkg;
    import rv_isa_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    REG_AW   = 5;
    localparam int    NUM_REGS = 1 << REG_AW;

    typedef enum logic {A_RS1, A_PC} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;
    typedef enum logic [1:0] {W_ALU, W_LOAD, W_PC4, W_IMM} w_sel_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_ex_t;

    typedef struct packed {
        alu_op_t    alu_op;
        a_sel_t     a_sel;
        b_sel_t     b_sel;
        logic       wen;
        w_sel_t     w_sel;
        logic       mem_rd;
        logic       mem_wr;
        mem_width_t width;
        logic       is_branch;
        branch_t    cond;
        logic       is_jump;
        logic       jalr;
        logic       halt;
    } ctrl_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // wishbone classic, master to slave and back
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] sel;
        word_t      adr;
        word_t      dat;
    } wb_m2s_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
    } wb_s2m_t;

endpackage

// ==== rv_alu.sv ====
// RV32I integer operations only; shift amount is taken from b[4:0]
`timescale 1ns/1ps

module rv_alu
    import rv_isa_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:  y = a + b;
            SUB:  y = a - b;
            SLL:  y = a << shamt;
            SLT:  y = {31'b0, $signed(a) < $signed(b)};
            SLTU: y = {31'b0, a < b};
            XOR:  y = a ^ b;
            SRL:  y = a >> shamt;
            SRA:  y = $unsigned($signed(a) >>> shamt);
            OR:   y = a | b;
            AND:  y = a & b;
            // illegal funct7/funct3 pairs
            default: y = '0;
        endcase
    end

endmodule

// ==== reg_file.sv ====
// 32 x 32 registers, two async reads and one write port; x0 always reads zero
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic [REG_AW-1:0] rd,
    input  word_t             wdata,
    input  logic              wen,
    output word_t             rs1_data,
    output word_t             rs2_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== rv_decoder.sv ====
// RV32I only; unknown opcodes decode to a no-op and every SYSTEM opcode to halt
`timescale 1ns/1ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  word_t             instr,
    output ctrl_t             ctrl,
    output word_t             imm,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output logic [REG_AW-1:0] rd
);

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            LUI: begin
                ctrl.wen   = 1'b1;
                ctrl.w_sel = W_IMM;
                imm        = imm_u;
            end
            AUIPC: begin
                ctrl.wen   = 1'b1;
                ctrl.a_sel = A_PC;
                ctrl.b_sel = B_IMM;
                imm        = imm_u;
            end
            JAL: begin
                ctrl.wen     = 1'b1;
                ctrl.w_sel   = W_PC4;
                ctrl.is_jump = 1'b1;
                imm          = imm_j;
            end
            JALR: begin
                ctrl.wen     = 1'b1;
                ctrl.w_sel   = W_PC4;
                ctrl.is_jump = 1'b1;
                ctrl.jalr    = 1'b1;
                imm          = imm_i;
            end
            BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.cond      = branch_t'(funct3);
                imm            = imm_b;
            end
            LOAD: begin
                ctrl.wen    = 1'b1;
                ctrl.w_sel  = W_LOAD;
                ctrl.mem_rd = 1'b1;
                ctrl.b_sel  = B_IMM;
                ctrl.width  = mem_width_t'(funct3);
                imm         = imm_i;
            end
            STORE: begin
                ctrl.mem_wr = 1'b1;
                ctrl.b_sel  = B_IMM;
                ctrl.width  = mem_width_t'(funct3);
                imm         = imm_s;
            end
            OP_IMM: begin
                ctrl.wen   = 1'b1;
                ctrl.b_sel = B_IMM;
                // bit 30 only selects SRA among the immediate forms
                ctrl.alu_op = alu_op_t'({funct3 == 3'b101 && instr[30], funct3});
                imm         = imm_i;
            end
            OP: begin
                ctrl.wen    = 1'b1;
                ctrl.alu_op = alu_op_t'({instr[30], funct3});
            end
            SYSTEM: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== fetch_stage.sv ====
// imem_data must be valid in the same cycle as imem_addr; static not-taken prediction
`timescale 1ns/1ps

module fetch_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      stall,
    input  redirect_t redirect,
    input  logic      halt,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output fetch_ex_t fetch_ex
);

    word_t pc;
    logic  valid_q;
    word_t pc_q;
    word_t instr_q;

    logic advance;

    assign advance   = !stall && !halt;
    assign imem_addr = pc;

    // redirect wins; execute only redirects when it is not stalled
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pc      <= RESET_PC;
            valid_q <= 1'b0;
        end else if (redirect.taken) begin
            pc      <= redirect.target;
            valid_q <= 1'b0;
        end else if (advance) begin
            pc      <= pc + 32'd4;
            valid_q <= 1'b1;
        end
    end

    // payload of the fetch/execute register
    always_ff @(posedge CLK) begin
        if (advance && !redirect.taken) begin
            pc_q    <= pc;
            instr_q <= imem_data;
        end
    end

    assign fetch_ex.valid = valid_q;
    assign fetch_ex.pc    = pc_q;
    assign fetch_ex.instr = instr_q;

endmodule

// ==== execute_stage.sv ====
// no misaligned-access checks; bus request is registered, so each access takes 2+ cycles
`timescale 1ns/1ps

module execute_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  fetch_ex_t fetch_ex,
    output redirect_t redirect,
    output logic      stall,
    output wb_m2s_t   wb_m2s,
    input  wb_s2m_t   wb_s2m,
    output logic      halt
);

    typedef enum logic {IDLE, WAIT} wb_state_t;

    ctrl_t             ctrl;
    word_t             imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    word_t             rs1_data;
    word_t             rs2_data;
    word_t             alu_a;
    word_t             alu_b;
    word_t             alu_y;
    word_t             wdata;
    word_t             pc4;
    word_t             jalr_sum;
    word_t             lane;
    word_t             load_data;
    logic              rf_wen;
    logic              ex_valid;
    logic              is_mem;
    logic              br_cond;
    logic              launch;
    logic              ack_done;

    wb_state_t  state;
    logic       req_q;
    logic       we_q;
    logic [3:0] sel_q;
    logic [3:0] sel_next;
    word_t      adr_q;
    word_t      dat_q;
    word_t      dat_next;

    rv_decoder i_rv_decoder (
        .instr (fetch_ex.instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    reg_file i_reg_file (
        .CLK      (CLK),
        .nRST     (nRST),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (wdata),
        .wen      (rf_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu i_rv_alu (
        .op (ctrl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    // nothing executes once halted
    assign ex_valid = fetch_ex.valid && !halt;
    assign is_mem   = ctrl.mem_rd || ctrl.mem_wr;
    assign alu_a    = (ctrl.a_sel == A_PC) ? fetch_ex.pc : rs1_data;
    assign alu_b    = (ctrl.b_sel == B_IMM) ? imm : rs2_data;
    assign pc4      = fetch_ex.pc + 32'd4;

    always_comb begin
        case (ctrl.cond)
            BEQ:     br_cond = rs1_data == rs2_data;
            BNE:     br_cond = rs1_data != rs2_data;
            BLT:     br_cond = $signed(rs1_data) < $signed(rs2_data);
            BGE:     br_cond = $signed(rs1_data) >= $signed(rs2_data);
            BLTU:    br_cond = rs1_data < rs2_data;
            BGEU:    br_cond = rs1_data >= rs2_data;
            default: br_cond = 1'b0;
        endcase
    end

    assign jalr_sum        = rs1_data + imm;
    assign redirect.taken  = ex_valid && (ctrl.is_jump || (ctrl.is_branch && br_cond));
    assign redirect.target = ctrl.jalr ? {jalr_sum[31:1], 1'b0} : fetch_ex.pc + imm;

    // byte lanes for the access, data replicated on all lanes
    always_comb begin
        case (ctrl.width)
            MB, MBU: begin
                sel_next = 4'b0001 << alu_y[1:0];
                dat_next = {4{rs2_data[7:0]}};
            end
            MH, MHU: begin
                sel_next = alu_y[1] ? 4'b1100 : 4'b0011;
                dat_next = {2{rs2_data[15:0]}};
            end
            default: begin
                sel_next = 4'b1111;
                dat_next = rs2_data;
            end
        endcase
    end

    // shift the addressed lane down, then extend
    assign lane = wb_s2m.dat >> {adr_q[1:0], 3'b000};

    always_comb begin
        case (ctrl.width)
            MB:      load_data = {{24{lane[7]}}, lane[7:0]};
            MBU:     load_data = {24'b0, lane[7:0]};
            MH:      load_data = {{16{lane[15]}}, lane[15:0]};
            MHU:     load_data = {16'b0, lane[15:0]};
            default: load_data = wb_s2m.dat;
        endcase
    end

    assign launch   = (state == IDLE) && ex_valid && is_mem;
    assign ack_done = (state == WAIT) && wb_s2m.ack;
    assign stall    = ex_valid && is_mem && !ack_done;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            req_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (launch) begin
                        state <= WAIT;
                        req_q <= 1'b1;
                    end
                end
                WAIT: begin
                    if (wb_s2m.ack) begin
                        state <= IDLE;
                        req_q <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // held stable until ack
    always_ff @(posedge CLK) begin
        if (launch) begin
            adr_q <= alu_y;
            we_q  <= ctrl.mem_wr;
            sel_q <= sel_next;
            dat_q <= dat_next;
        end
    end

    assign wb_m2s.cyc = req_q;
    assign wb_m2s.stb = req_q;
    assign wb_m2s.we  = we_q;
    assign wb_m2s.sel = sel_q;
    assign wb_m2s.adr = adr_q;
    assign wb_m2s.dat = dat_q;

    // plain ops write when not stalled, loads on their ack
    assign rf_wen = (ex_valid && ctrl.wen && !is_mem) || (ack_done && ctrl.mem_rd);

    always_comb begin
        case (ctrl.w_sel)
            W_LOAD:  wdata = load_data;
            W_PC4:   wdata = pc4;
            W_IMM:   wdata = imm;
            default: wdata = alu_y;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            halt <= 1'b0;
        end else if (ex_valid && ctrl.halt) begin
            halt <= 1'b1;
        end
    end

endmodule

// ==== core_top.sv ====
// two-stage RV32I core; imem is a combinational read port, dmem is Wishbone classic
`timescale 1ns/1ps

module core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    output word_t   imem_addr,
    input  word_t   imem_data,
    output wb_m2s_t wb_m2s,
    input  wb_s2m_t wb_s2m,
    output logic    halt
);

    fetch_ex_t fetch_ex;
    redirect_t redirect;
    logic      stall;

    fetch_stage i_fetch_stage (
        .CLK       (CLK),
        .nRST      (nRST),
        .stall     (stall),
        .redirect  (redirect),
        .halt      (halt),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fetch_ex  (fetch_ex)
    );

    execute_stage i_execute_stage (
        .CLK      (CLK),
        .nRST     (nRST),
        .fetch_ex (fetch_ex),
        .redirect (redirect),
        .stall    (stall),
        .wb_m2s   (wb_m2s),
        .wb_s2m   (wb_s2m),
        .halt     (halt)
    );

endmodule

// ==== tb_core.sv ====
// fixed hand-encoded program; data memory covers 0x000-0x0ff and acks after 0-3 random waits
`timescale 1ns/1ps

module tb_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int    ROM_WORDS  = 128;
    localparam int    DMEM_WORDS = 64;
    localparam word_t OP_A       = 32'hF0F0_1234;
    localparam word_t OP_B       = 32'h0000_070D;
    localparam word_t BYTE_SRC   = 32'h1234_A5F6;
    localparam word_t MARKER     = 32'h0BAD_0777;
    localparam word_t NOP        = 32'h0000_0013;

    logic    CLK    = 1'b0;
    logic    nRST   = 1'b0;
    wb_s2m_t wb_s2m = '0;
    word_t   imem_addr;
    word_t   imem_data;
    wb_m2s_t wb_m2s;
    logic    halt;

    word_t       rom     [ROM_WORDS];
    word_t       dmem    [DMEM_WORDS];
    word_t       exp_mem [DMEM_WORDS];
    word_t       exp_adr [$];
    logic [3:0]  exp_sel [$];
    word_t       exp_dat [$];
    int          prog_len  = 0;
    int          errors    = 0;
    int unsigned cycles    = 0;
    logic [31:0] rng       = 32'd51149;
    logic        busy      = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    word_t       merged;

    always #10 CLK = ~CLK;

    always @(posedge CLK) cycles <= cycles + 1;

    core_top i_core_top (
        .CLK       (CLK),
        .nRST      (nRST),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_m2s    (wb_m2s),
        .wb_s2m    (wb_s2m),
        .halt      (halt)
    );

    // combinational instruction port
    assign imem_data = rom[imem_addr[8:2]];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t fill_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input logic [3:0] sel, input word_t dat);
        word_t r;
        int    i;
        r = old;
        for (i = 0; i < 4; i++) begin
            if (sel[i]) r[i*8 +: 8] = dat[i*8 +: 8];
        end
        return r;
    endfunction

    // instruction encoders
    function automatic word_t enc_r(input logic [9:0] f7f3, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [4:0] rd);
        return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // funct7 and funct3 of the k-th register operation
    function automatic logic [9:0] alu_fields(input int k);
        case (k)
            0:       return {7'h00, 3'b000};  // add
            1:       return {7'h20, 3'b000};  // sub
            2:       return {7'h00, 3'b001};  // sll
            3:       return {7'h00, 3'b010};  // slt
            4:       return {7'h00, 3'b011};  // sltu
            5:       return {7'h00, 3'b100};  // xor
            6:       return {7'h00, 3'b101};  // srl
            7:       return {7'h20, 3'b101};  // sra
            8:       return {7'h00, 3'b110};  // or
            default: return {7'h00, 3'b111};  // and
        endcase
    endfunction

    function automatic word_t alu_ref(input int k, input word_t a, input word_t b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return word_t'($signed(a) >>> b[4:0]);
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic string region_name(input int idx);
        if (idx < 16) return "alu";
        if (idx < 32) return "byte_half";
        return "branch_jump";
    endfunction

    function automatic word_t cur_pc();
        return RESET_PC + word_t'(prog_len) * 32'd4;
    endfunction

    task automatic emit(input word_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic emit_li(input logic [4:0] rd, input word_t val);
        logic [19:0] upper;
        // addi sign-extends, so round the upper part
        upper = val[31:12] + {19'd0, val[11]};
        emit(enc_u(upper, rd, LUI));
        emit(enc_i(val[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    // store from rs2 at addr(x0) and record the bus access it must make
    task automatic emit_store(input mem_width_t w, input logic [4:0] rs2,
                              input logic [11:0] addr, input word_t value);
        logic [3:0] sel;
        word_t      dat;
        int         size;
        int         off;
        int         i;
        case (w)
            MB:      size = 1;
            MH:      size = 2;
            default: size = 4;
        endcase
        off = int'(addr[1:0]);
        // lanes the access covers, source bytes repeated over the whole word
        for (i = 0; i < 4; i++) begin
            sel[i]        = (i >= off) && (i < off + size);
            dat[i*8 +: 8] = value[(i % size)*8 +: 8];
        end
        emit(enc_s(addr, rs2, 5'd0, w));
        exp_adr.push_back({20'd0, addr});
        exp_sel.push_back(sel);
        exp_dat.push_back(dat);
        exp_mem[addr[7:2]] = merge_lanes(exp_mem[addr[7:2]], sel, dat);
    endtask

    // load into x5, then store x5 as a word at dst
    task automatic emit_load(input mem_width_t w, input logic [11:0] addr,
                             input logic [11:0] dst);
        word_t word;
        word_t shifted;
        word_t value;
        word    = exp_mem[addr[7:2]];
        shifted = word >> (8 * addr[1:0]);
        case (w)
            MB:      value = {{24{shifted[7]}}, shifted[7:0]};
            MBU:     value = {24'd0, shifted[7:0]};
            MH:      value = {{16{shifted[15]}}, shifted[15:0]};
            MHU:     value = {16'd0, shifted[15:0]};
            default: value = word;
        endcase
        emit(enc_i(addr, 5'd0, w, 5'd5, LOAD));
        emit_store(MW, 5'd5, dst, value);
    endtask

    task automatic build_program();
        word_t link;
        int    k;
        for (k = 0; k < ROM_WORDS; k++) begin
            rom[k] = NOP;
        end
        for (k = 0; k < DMEM_WORDS; k++) begin
            dmem[k]    = fill_word(word_t'(k) << 2);
            exp_mem[k] = dmem[k];
        end
        // each alu op on x1 and x2 with one result word per op
        emit_li(5'd1, OP_A);
        emit_li(5'd2, OP_B);
        for (k = 0; k < 10; k++) begin
            emit(enc_r(alu_fields(k), 5'd2, 5'd1, 5'd3));
            emit_store(MW, 5'd3, 12'(k * 4), alu_ref(k, OP_A, OP_B));
        end
        // byte at every offset, half at both, then read back
        emit_li(5'd4, BYTE_SRC);
        emit_store(MB, 5'd4, 12'h040, BYTE_SRC);
        emit_store(MB, 5'd4, 12'h045, BYTE_SRC);
        emit_store(MB, 5'd4, 12'h04A, BYTE_SRC);
        emit_store(MB, 5'd4, 12'h04F, BYTE_SRC);
        emit_store(MH, 5'd4, 12'h050, BYTE_SRC);
        emit_store(MH, 5'd4, 12'h056, BYTE_SRC);
        emit_load(MB, 12'h045, 12'h060);
        emit_load(MBU, 12'h04A, 12'h064);
        emit_load(MH, 12'h056, 12'h068);
        emit_load(MHU, 12'h050, 12'h06C);
        emit_load(MH, 12'h054, 12'h070);
        emit_load(MW, 12'h04C, 12'h074);
        // taken branches skip the marker store
        emit_li(5'd6, MARKER);
        emit(enc_b(13'd8, 5'd1, 5'd1, BEQ));
        emit(enc_s(12'h080, 5'd6, 5'd0, MW));
        emit(enc_b(13'd8, 5'd1, 5'd1, BNE));
        emit_store(MW, 5'd6, 12'h084, MARKER);
        emit(enc_b(13'd8, 5'd2, 5'd1, BLT));
        emit(enc_s(12'h088, 5'd6, 5'd0, MW));
        emit(enc_b(13'd8, 5'd1, 5'd2, BGEU));
        emit_store(MW, 5'd6, 12'h08C, MARKER);
        link = cur_pc() + 32'd4;
        emit(enc_j(21'd8, 5'd7));
        emit(enc_s(12'h090, 5'd6, 5'd0, MW));
        emit_store(MW, 5'd7, 12'h094, link);
        // odd jalr offset whose bit 0 is dropped
        emit(enc_u(20'd0, 5'd8, AUIPC));
        link = cur_pc() + 32'd4;
        emit(enc_i(12'd13, 5'd8, 3'b000, 5'd9, JALR));
        emit(enc_s(12'h098, 5'd6, 5'd0, MW));
        emit_store(MW, 5'd9, 12'h09C, link);
        // ebreak, then a store that must never run
        emit({12'h001, 5'd0, 3'b000, 5'd0, SYSTEM});
        emit(enc_s(12'h0A0, 5'd6, 5'd0, MW));
    endtask

    task automatic check_store(input word_t adr, input logic [3:0] sel, input word_t dat);
        word_t      e_adr;
        logic [3:0] e_sel;
        word_t      e_dat;
        if (exp_adr.size() == 0) begin
            errors++;
            $display("unexpected store to %h after the last expected store", adr);
        end else begin
            e_adr = exp_adr.pop_front();
            e_sel = exp_sel.pop_front();
            e_dat = exp_dat.pop_front();
            assert (adr == e_adr) else begin
                errors++;
                $display("ERR store_adr expected %h actual %h", e_adr, adr);
            end
            assert (sel == e_sel) else begin
                errors++;
                $display("ERR store_sel at %h expected %b actual %b", e_adr, e_sel, sel);
            end
            assert (dat == e_dat) else begin
                errors++;
                $display("ERR store_dat at %h expected %h actual %h", e_adr, e_dat, dat);
            end
        end
    endtask

    // wishbone slave with a random wait before each ack
    always @(posedge CLK) begin
        if (!nRST) begin
            wb_s2m <= '0;
            busy   = 1'b0;
        end else if (wb_m2s.stb && !wb_s2m.ack) begin
            if (!busy) begin
                rng       = xorshift32(rng);
                wait_left = rng[1:0];
                busy      = 1'b1;
            end
            if (wait_left != 2'd0) begin
                wait_left = wait_left - 2'd1;
            end else begin
                busy       = 1'b0;
                wb_s2m.ack <= 1'b1;
                if (wb_m2s.we) begin
                    merged = merge_lanes(dmem[wb_m2s.adr[7:2]], wb_m2s.sel, wb_m2s.dat);
                    dmem[wb_m2s.adr[7:2]] = merged;
                    $display("store adr=%h sel=%b data=%h", wb_m2s.adr, wb_m2s.sel, merged);
                    check_store(wb_m2s.adr, wb_m2s.sel, wb_m2s.dat);
                end else begin
                    wb_s2m.dat <= dmem[wb_m2s.adr[7:2]];
                end
            end
        end else begin
            wb_s2m.ack <= 1'b0;
        end
    end

    reset_state: assert property (@(posedge CLK)
        (cycles != 0 && (!nRST || $rose(nRST))) |->
            (!wb_m2s.cyc && !wb_m2s.stb && !halt && imem_addr == RESET_PC))
        else begin
            errors++;
            $display("ERR reset_state expected cyc=0 stb=0 halt=0 pc=%h actual %b %b %b %h",
                RESET_PC, $sampled(wb_m2s.cyc), $sampled(wb_m2s.stb), $sampled(halt),
                $sampled(imem_addr));
        end

    wb_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_m2s.stb && !wb_s2m.ack) |=> $stable(wb_m2s))
        else begin
            errors++;
            $display("wishbone request changed before its ack at %0t", $time);
        end

    wb_release: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_m2s.stb && wb_s2m.ack) |=> (!wb_m2s.cyc && !wb_m2s.stb))
        else begin
            errors++;
            $display("cyc or stb still high in the cycle after ack at %0t", $time);
        end

    halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
        else begin
            errors++;
            $display("halt dropped after it was raised at %0t", $time);
        end

    halt_quiet: assert property (@(posedge CLK) disable iff (!nRST) halt |-> !wb_m2s.stb)
        else begin
            errors++;
            $display("bus strobe seen while halted at %0t", $time);
        end

    // worst case of ten cycles per instruction once reset is released
    initial begin
        wait (nRST);
        #((prog_len * 10 + 16) * 20);
        $display("timeout: the core did not halt within %0d cycles", prog_len * 10 + 16);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int i;
        build_program();
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        wait (halt);
        // a few more cycles so a stray bus cycle would be caught
        repeat (8) @(posedge CLK);
        for (i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] == exp_mem[i]) else begin
                errors++;
                $display("ERR %s at %h expected %h actual %h",
                    region_name(i), i * 4, exp_mem[i], dmem[i]);
            end
        end
        assert (exp_adr.size() == 0) else begin
            errors++;
            $display("%0d expected stores never reached the bus", exp_adr.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_alu.sv
reg_file.sv
rv_decoder.sv
fetch_stage.sv
execute_stage.sv
core_top.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and pass only if the pass message shows up
verilator --binary --assert --top-module tb_core -f src.f -o tb_core_sim \
    && ./obj_dir/tb_core_sim | tee /dev/stderr | grep -q "Testbench passed" \
    || exit 1
